/* rtl/soc_cfg.svh */
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// Address map
`define SOC_MEM_START 32'h0000_0000
`define SOC_MEM_END 32'h0000_0FFF
`define SOC_GPIO_START 32'h0000_1000
`define SOC_GPIO_END 32'h0000_100F

// On-chip memory depth in 32-bit words
`define SOC_MEM_WORDS 1024

// UART bit period in clock cycles
`define SOC_CLKS_PER_BIT 16

// GPIO register offsets
`define SOC_GPIO_LED_OFS 0
`define SOC_GPIO_SW_OFS 4

`endif

/* rtl/bus_pkg.sv */
package bus_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0] strb_t;

	typedef enum logic [1:0] {
		OKAY = 2'b00,
		DECERR = 2'b11
	} resp_e;

	// Master to slave
	typedef struct packed {
		logic awvalid;
		addr_t awaddr;
		logic wvalid;
		data_t wdata;
		strb_t wstrb;
		logic bready;
		logic arvalid;
		addr_t araddr;
		logic rready;
	} axi_req_t;

	// Slave to master
	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		resp_e bresp;
		logic arready;
		logic rvalid;
		data_t rdata;
		resp_e rresp;
	} axi_rsp_t;

endpackage

/* rtl/serial_pkg.sv */
package serial_pkg;

	typedef logic [7:0] byte_t;

	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		STOP
	} rx_state_e;

	typedef enum logic [1:0] {
		COUNT, // Collecting the word count
		WORD,
		WRITE,
		RESP
	} load_state_e;

endpackage

/* rtl/uart_rx.sv */
`include "soc_cfg.svh"

module uart_rx (
	input logic clk_i,
	input logic reset_i,
	input logic rx_i,
	output serial_pkg::byte_t byte_o,
	output logic byte_valid_o
);

	localparam int CNT_W = $clog2(`SOC_CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(`SOC_CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`SOC_CLKS_PER_BIT - 1);

	logic [1:0] sync_q;
	logic rx;
	logic [CNT_W-1:0] cnt_q;
	logic [2:0] bit_q;
	serial_pkg::byte_t shift_q;
	serial_pkg::rx_state_e state_q;

	assign rx = sync_q[1];
	assign byte_o = shift_q;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			sync_q <= 2'b11; // Line idles high
			state_q <= serial_pkg::IDLE;
			cnt_q <= '0;
			bit_q <= '0;
			byte_valid_o <= 1'b0;
		end else begin
			sync_q <= {sync_q[0], rx_i};
			byte_valid_o <= 1'b0;
			case (state_q)
				serial_pkg::IDLE: begin
					cnt_q <= '0;
					if (!rx)
						state_q <= serial_pkg::START;
				end
				serial_pkg::START: begin
					if (cnt_q == HALF_BIT) begin
						cnt_q <= '0;
						bit_q <= '0;
						// Glitch shorter than half a bit
						state_q <= rx ? serial_pkg::IDLE : serial_pkg::DATA;
					end else begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
				serial_pkg::DATA: begin
					if (cnt_q == FULL_BIT) begin
						cnt_q <= '0;
						shift_q <= {rx, shift_q[7:1]}; // LSB first
						bit_q <= bit_q + 1'b1;
						if (bit_q == 3'd7)
							state_q <= serial_pkg::STOP;
					end else begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
				default: begin
					if (cnt_q == FULL_BIT) begin
						cnt_q <= '0;
						byte_valid_o <= rx; // Framing error drops the byte
						state_q <= serial_pkg::IDLE;
					end else begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
			endcase
		end
	end

endmodule

/* rtl/prog_loader.sv */
`include "soc_cfg.svh"

module prog_loader (
	input logic clk_i,
	input logic reset_i,
	input logic rx_i,
	output bus_pkg::axi_req_t mem_req_o,
	input bus_pkg::axi_rsp_t mem_rsp_i,
	output logic busy_o
);

	serial_pkg::byte_t rx_byte;
	logic rx_valid;
	logic last_byte;
	logic [1:0] byte_cnt_q;
	serial_pkg::load_state_e state_q;
	bus_pkg::data_t shift_q;
	bus_pkg::data_t assembled;
	bus_pkg::data_t wdata_q;
	bus_pkg::data_t words_q; // Words still to write
	bus_pkg::addr_t addr_q;

	uart_rx u_uart_rx (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.rx_i(rx_i),
		.byte_o(rx_byte),
		.byte_valid_o(rx_valid)
	);

	// Little-endian, newest byte lands on top
	assign assembled = {rx_byte, shift_q[31:8]};
	assign last_byte = rx_valid && (byte_cnt_q == 2'd3);

	always_comb begin
		mem_req_o = '0;
		mem_req_o.awvalid = (state_q == serial_pkg::WRITE);
		mem_req_o.awaddr = addr_q;
		mem_req_o.wvalid = (state_q == serial_pkg::WRITE);
		mem_req_o.wdata = wdata_q;
		mem_req_o.wstrb = '1;
		mem_req_o.bready = 1'b1;
		mem_req_o.rready = 1'b1; // Drains a read left over from the bus side
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q <= serial_pkg::COUNT;
			byte_cnt_q <= '0;
			words_q <= '0;
			addr_q <= `SOC_MEM_START;
			busy_o <= 1'b0;
		end else begin
			if (rx_valid) begin
				shift_q <= assembled;
				byte_cnt_q <= byte_cnt_q + 1'b1;
			end
			case (state_q)
				serial_pkg::COUNT: begin
					if (rx_valid)
						busy_o <= 1'b1;
					if (last_byte) begin
						words_q <= assembled;
						addr_q <= `SOC_MEM_START;
						if (assembled == '0)
							busy_o <= 1'b0; // Empty image
						else
							state_q <= serial_pkg::WORD;
					end
				end
				serial_pkg::WORD: begin
					if (last_byte) begin
						wdata_q <= assembled;
						state_q <= serial_pkg::WRITE;
					end
				end
				serial_pkg::WRITE: begin
					if (mem_rsp_i.awready && mem_rsp_i.wready)
						state_q <= serial_pkg::RESP;
				end
				default: begin
					if (mem_rsp_i.bvalid) begin
						addr_q <= addr_q + 32'd4;
						words_q <= words_q - 1'b1;
						if (words_q == 32'd1) begin
							state_q <= serial_pkg::COUNT;
							busy_o <= 1'b0;
						end else begin
							state_q <= serial_pkg::WORD;
						end
					end
				end
			endcase
		end
	end

endmodule

/* rtl/axi_crossbar.sv */
module axi_crossbar #(
	parameter int ENDPOINTS = 2
) (
	input logic clk_i,
	input logic reset_i,
	input bus_pkg::axi_req_t mst_req_i,
	output bus_pkg::axi_rsp_t mst_rsp_o,
	input bus_pkg::addr_t ranges_i [ENDPOINTS][2], // [e][0] start, [e][1] end
	output bus_pkg::axi_req_t slv_req_o [ENDPOINTS],
	input bus_pkg::axi_rsp_t slv_rsp_i [ENDPOINTS]
);

	localparam int SEL_W = (ENDPOINTS > 1) ? $clog2(ENDPOINTS) : 1;

	typedef logic [SEL_W-1:0] sel_t;

	typedef struct packed {
		logic hit;
		sel_t idx;
	} dec_t;

	dec_t aw_dec;
	dec_t ar_dec;
	logic w_busy_q, w_err_q;
	logic r_busy_q, r_err_q;
	sel_t w_sel_q, r_sel_q;

	// Lowest matching entry wins
	function automatic dec_t decode(bus_pkg::addr_t addr);
		dec_t d;
		d = '0;
		for (int e = ENDPOINTS - 1; e >= 0; e--) begin
			if (addr >= ranges_i[e][0] && addr <= ranges_i[e][1]) begin
				d.hit = 1'b1;
				d.idx = sel_t'(e);
			end
		end
		return d;
	endfunction

	always_comb begin
		aw_dec = decode(mst_req_i.awaddr);
		ar_dec = decode(mst_req_i.araddr);
	end

	always_comb begin
		mst_rsp_o = '0;
		for (int e = 0; e < ENDPOINTS; e++) begin
			slv_req_o[e] = '0;
			slv_req_o[e].awaddr = mst_req_i.awaddr;
			slv_req_o[e].wdata = mst_req_i.wdata;
			slv_req_o[e].wstrb = mst_req_i.wstrb;
			slv_req_o[e].araddr = mst_req_i.araddr;
		end

		// Write path
		if (!w_busy_q) begin
			if (aw_dec.hit) begin
				slv_req_o[aw_dec.idx].awvalid = mst_req_i.awvalid;
				slv_req_o[aw_dec.idx].wvalid = mst_req_i.wvalid;
				mst_rsp_o.awready = slv_rsp_i[aw_dec.idx].awready;
				mst_rsp_o.wready = slv_rsp_i[aw_dec.idx].wready;
			end else begin
				mst_rsp_o.awready = mst_req_i.awvalid & mst_req_i.wvalid; // Swallow unmapped
				mst_rsp_o.wready = mst_req_i.awvalid & mst_req_i.wvalid;
			end
		end else if (w_err_q) begin
			mst_rsp_o.bvalid = 1'b1;
			mst_rsp_o.bresp = bus_pkg::DECERR;
		end else begin
			slv_req_o[w_sel_q].bready = mst_req_i.bready;
			mst_rsp_o.bvalid = slv_rsp_i[w_sel_q].bvalid;
			mst_rsp_o.bresp = slv_rsp_i[w_sel_q].bresp;
		end

		// Read path
		if (!r_busy_q) begin
			if (ar_dec.hit) begin
				slv_req_o[ar_dec.idx].arvalid = mst_req_i.arvalid;
				mst_rsp_o.arready = slv_rsp_i[ar_dec.idx].arready;
			end else begin
				mst_rsp_o.arready = mst_req_i.arvalid;
			end
		end else if (r_err_q) begin
			mst_rsp_o.rvalid = 1'b1;
			mst_rsp_o.rresp = bus_pkg::DECERR; // rdata stays zero
		end else begin
			slv_req_o[r_sel_q].rready = mst_req_i.rready;
			mst_rsp_o.rvalid = slv_rsp_i[r_sel_q].rvalid;
			mst_rsp_o.rdata = slv_rsp_i[r_sel_q].rdata;
			mst_rsp_o.rresp = slv_rsp_i[r_sel_q].rresp;
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			w_busy_q <= 1'b0;
			w_err_q <= 1'b0;
			w_sel_q <= '0;
			r_busy_q <= 1'b0;
			r_err_q <= 1'b0;
			r_sel_q <= '0;
		end else begin
			if (!w_busy_q) begin
				if (mst_req_i.awvalid && mst_rsp_o.awready && mst_req_i.wvalid && mst_rsp_o.wready) begin
					w_busy_q <= 1'b1;
					w_sel_q <= aw_dec.idx;
					w_err_q <= !aw_dec.hit;
				end
			end else if (mst_rsp_o.bvalid && mst_req_i.bready) begin
				w_busy_q <= 1'b0;
			end

			if (!r_busy_q) begin
				if (mst_req_i.arvalid && mst_rsp_o.arready) begin
					r_busy_q <= 1'b1;
					r_sel_q <= ar_dec.idx;
					r_err_q <= !ar_dec.hit;
				end
			end else if (mst_rsp_o.rvalid && mst_req_i.rready) begin
				r_busy_q <= 1'b0;
			end
		end
	end

endmodule

/* rtl/bram_axi.sv */
`include "soc_cfg.svh"

module bram_axi (
	input logic clk_i,
	input logic reset_i,
	input bus_pkg::axi_req_t req_i,
	output bus_pkg::axi_rsp_t rsp_o
);

	localparam int IDX_W = $clog2(`SOC_MEM_WORDS);

	bus_pkg::data_t mem [`SOC_MEM_WORDS];
	bus_pkg::data_t rdata_q;
	logic bvalid_q, rvalid_q;
	logic wr_acc, rd_acc;
	logic [IDX_W-1:0] widx, ridx;

	assign widx = req_i.awaddr[IDX_W+1:2];
	assign ridx = req_i.araddr[IDX_W+1:2];
	assign wr_acc = req_i.awvalid & req_i.wvalid & ~bvalid_q;
	assign rd_acc = req_i.arvalid & ~rvalid_q & ~wr_acc; // One port, write goes first

	always_comb begin
		rsp_o = '0;
		rsp_o.awready = wr_acc;
		rsp_o.wready = wr_acc;
		rsp_o.bvalid = bvalid_q;
		rsp_o.bresp = bus_pkg::OKAY;
		rsp_o.arready = rd_acc;
		rsp_o.rvalid = rvalid_q;
		rsp_o.rdata = rdata_q;
		rsp_o.rresp = bus_pkg::OKAY;
	end

	always_ff @(posedge clk_i) begin
		if (wr_acc) begin
			for (int i = 0; i < 4; i++) begin
				if (req_i.wstrb[i])
					mem[widx][8*i +: 8] <= req_i.wdata[8*i +: 8];
			end
		end
		if (rd_acc)
			rdata_q <= mem[ridx];
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			if (wr_acc)
				bvalid_q <= 1'b1;
			else if (req_i.bready)
				bvalid_q <= 1'b0;
			if (rd_acc)
				rvalid_q <= 1'b1;
			else if (req_i.rready)
				rvalid_q <= 1'b0;
		end
	end

endmodule

/* rtl/gpio_axi.sv */
`include "soc_cfg.svh"

module gpio_axi (
	input logic clk_i,
	input logic reset_i,
	input bus_pkg::axi_req_t req_i,
	output bus_pkg::axi_rsp_t rsp_o,
	input logic [3:0] sw_i,
	output logic [7:0] led_o
);

	bus_pkg::addr_t aw_ofs, ar_ofs;
	bus_pkg::data_t rdata_q;
	logic bvalid_q, rvalid_q;
	logic wr_acc, rd_acc;
	logic [7:0] led_q;
	logic [3:0] sw_meta_q, sw_sync_q;

	assign aw_ofs = req_i.awaddr - `SOC_GPIO_START;
	assign ar_ofs = req_i.araddr - `SOC_GPIO_START;
	assign wr_acc = req_i.awvalid & req_i.wvalid & ~bvalid_q;
	assign rd_acc = req_i.arvalid & ~rvalid_q;
	assign led_o = led_q;

	always_comb begin
		rsp_o = '0;
		rsp_o.awready = wr_acc;
		rsp_o.wready = wr_acc;
		rsp_o.bvalid = bvalid_q;
		rsp_o.bresp = bus_pkg::OKAY;
		rsp_o.arready = rd_acc;
		rsp_o.rvalid = rvalid_q;
		rsp_o.rdata = rdata_q;
		rsp_o.rresp = bus_pkg::OKAY;
	end

	always_ff @(posedge clk_i) begin
		if (rd_acc) begin
			case (ar_ofs)
				`SOC_GPIO_LED_OFS: rdata_q <= {24'd0, led_q};
				`SOC_GPIO_SW_OFS: rdata_q <= {28'd0, sw_sync_q};
				default: rdata_q <= '0;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			led_q <= '0;
			sw_meta_q <= '0;
			sw_sync_q <= '0;
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			sw_meta_q <= sw_i; // Switches are asynchronous
			sw_sync_q <= sw_meta_q;
			if (wr_acc && aw_ofs == `SOC_GPIO_LED_OFS)
				led_q <= req_i.wdata[7:0];
			if (wr_acc)
				bvalid_q <= 1'b1;
			else if (req_i.bready)
				bvalid_q <= 1'b0;
			if (rd_acc)
				rvalid_q <= 1'b1;
			else if (req_i.rready)
				rvalid_q <= 1'b0;
		end
	end

endmodule

/* rtl/soc_top.sv */
`include "soc_cfg.svh"

module soc_top (
	input logic clk_i,
	input logic reset_i,
	input logic [3:0] sw_i,
	input logic uart_rx_i,
	output logic [7:0] led_o, // {red, plain}
	output logic loader_busy_o,
	input bus_pkg::axi_req_t ext_req_i,
	output bus_pkg::axi_rsp_t ext_rsp_o
);

	localparam int ENDPOINTS = 2;

	logic reprogram;
	logic sys_reset;
	bus_pkg::addr_t ranges [ENDPOINTS][2];
	bus_pkg::axi_req_t xbar_mst_req;
	bus_pkg::axi_req_t xbar_req [ENDPOINTS];
	bus_pkg::axi_rsp_t xbar_rsp [ENDPOINTS];
	bus_pkg::axi_req_t loader_req;
	bus_pkg::axi_req_t mem_req;
	bus_pkg::axi_rsp_t mem_rsp;

	assign reprogram = sw_i[1] | loader_busy_o;
	assign sys_reset = reset_i | reprogram;

	assign ranges[0][0] = `SOC_MEM_START;
	assign ranges[0][1] = `SOC_MEM_END;
	assign ranges[1][0] = `SOC_GPIO_START;
	assign ranges[1][1] = `SOC_GPIO_END;

	// Memory belongs to the loader while reprogramming
	assign xbar_mst_req = reprogram ? '0 : ext_req_i;
	assign mem_req = reprogram ? loader_req : xbar_req[0];
	assign xbar_rsp[0] = reprogram ? '0 : mem_rsp;

	prog_loader u_prog_loader (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.rx_i(uart_rx_i),
		.mem_req_o(loader_req),
		.mem_rsp_i(mem_rsp),
		.busy_o(loader_busy_o)
	);

	axi_crossbar #(
		.ENDPOINTS(ENDPOINTS)
	) u_axi_crossbar (
		.clk_i(clk_i),
		.reset_i(sys_reset),
		.mst_req_i(xbar_mst_req),
		.mst_rsp_o(ext_rsp_o),
		.ranges_i(ranges),
		.slv_req_o(xbar_req),
		.slv_rsp_i(xbar_rsp)
	);

	bram_axi u_bram_axi (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.req_i(mem_req),
		.rsp_o(mem_rsp)
	);

	gpio_axi u_gpio_axi (
		.clk_i(clk_i),
		.reset_i(sys_reset),
		.req_i(xbar_req[1]),
		.rsp_o(xbar_rsp[1]),
		.sw_i(sw_i),
		.led_o(led_o)
	);

endmodule

/* bench/tb_clock.sv */
module tb_clock #(
	parameter int PERIOD = 100
) (
	output logic clk_o
);
	timeunit 1ns;
	timeprecision 100ps;

	initial clk_o = 1'b0;

	always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

/* bench/soc_props.sv */
module soc_props (
	input logic clk_i,
	input logic reset_i,
	input logic reprogram_i,
	input logic [7:0] led_i,
	input bus_pkg::axi_req_t ext_req_i,
	input bus_pkg::axi_rsp_t ext_rsp_i
);
	timeunit 1ns;
	timeprecision 100ps;

	logic rsp_active;

	assign rsp_active = ext_rsp_i.awready | ext_rsp_i.wready | ext_rsp_i.bvalid
		| ext_rsp_i.arready | ext_rsp_i.rvalid;

	bvalid_held: assert property (@(posedge clk_i) disable iff (reset_i)
		ext_rsp_i.bvalid && !ext_req_i.bready |=> ext_rsp_i.bvalid)
		else $error("bvalid dropped before bready");

	rvalid_held: assert property (@(posedge clk_i) disable iff (reset_i)
		ext_rsp_i.rvalid && !ext_req_i.rready |=> ext_rsp_i.rvalid && $stable(ext_rsp_i.rdata))
		else $error("rvalid or rdata changed before rready");

	// Crossbar and GPIO sit in reset
	quiet_reprogram: assert property (@(posedge clk_i) disable iff (reset_i)
		reprogram_i |-> !rsp_active)
		else $error("handshake activity on the external port while reprogramming");

	led_after_reset: assert property (@(posedge clk_i)
		reset_i |=> led_i == 8'h00)
		else $error("LEDs not cleared after reset");

endmodule

bind soc_top soc_props u_soc_props (
	.clk_i(clk_i),
	.reset_i(reset_i),
	.reprogram_i(reprogram),
	.led_i(led_o),
	.ext_req_i(ext_req_i),
	.ext_rsp_i(ext_rsp_o)
);

/* bench/soc_tb.sv */
`include "soc_cfg.svh"

module soc_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int DRIVE_DLY = 1;
	localparam int BUS_TIMEOUT = 20;
	localparam int LOAD_TIMEOUT = 200;
	localparam int IMG_WORDS = 8;
	localparam logic [3:0] SW_PATTERN = 4'b1101; // Bit 1 clear

	typedef struct {
		bit is_write;
		bus_pkg::addr_t addr;
		bus_pkg::data_t data;
		bus_pkg::strb_t strb;
		bus_pkg::data_t exp_data;
		bus_pkg::resp_e exp_resp;
	} entry_t;

	logic clk;
	logic reset;
	logic [3:0] sw;
	logic uart_rx;
	logic [7:0] led;
	logic loader_busy;
	bus_pkg::axi_req_t ext_req;
	bus_pkg::axi_rsp_t ext_rsp;

	bus_pkg::data_t model [IMG_WORDS]; // Expected image contents
	entry_t stim_q [$];

	tb_clock #(
		.PERIOD(100)
	) u_tb_clock (
		.clk_o(clk)
	);

	soc_top u_soc_top (
		.clk_i(clk),
		.reset_i(reset),
		.sw_i(sw),
		.uart_rx_i(uart_rx),
		.led_o(led),
		.loader_busy_o(loader_busy),
		.ext_req_i(ext_req),
		.ext_rsp_o(ext_rsp)
	);

	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(string name, logic [31:0] exp, logic [31:0] got);
		assert (got === exp)
		else begin
			$display("MISMATCH at %0t ns: %s expected %h got %h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	// 8N1, LSB first
	task automatic send_byte(serial_pkg::byte_t b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			uart_rx = frame[i];
			repeat (`SOC_CLKS_PER_BIT) next_cycle();
		end
	endtask

	task automatic send_word(bus_pkg::data_t w);
		for (int i = 0; i < 4; i++)
			send_byte(w[8*i +: 8]);
	endtask

	task automatic wait_load_done();
		int n;
		n = 0;
		@(negedge clk);
		while (loader_busy) begin
			n++;
			if (n > LOAD_TIMEOUT) begin
				$display("Loader still busy long after the last byte was sent");
				abort_run();
			end
			@(negedge clk);
		end
		next_cycle();
	endtask

	task automatic bus_write(bus_pkg::addr_t addr, bus_pkg::data_t data, bus_pkg::strb_t strb,
			output bus_pkg::resp_e resp);
		int n;
		ext_req.awvalid = 1'b1;
		ext_req.awaddr = addr;
		ext_req.wvalid = 1'b1;
		ext_req.wdata = data;
		ext_req.wstrb = strb;
		ext_req.bready = 1'b0;
		n = 0;
		@(negedge clk);
		while (!(ext_rsp.awready && ext_rsp.wready)) begin
			n++;
			if (n > BUS_TIMEOUT) begin
				$display("No awready/wready for the write to address %h", addr);
				abort_run();
			end
			@(negedge clk);
		end
		next_cycle();
		ext_req.awvalid = 1'b0;
		ext_req.wvalid = 1'b0;
		n = 0;
		@(negedge clk);
		while (!ext_rsp.bvalid) begin
			n++;
			if (n > BUS_TIMEOUT) begin
				$display("No write response for address %h", addr);
				abort_run();
			end
			@(negedge clk);
		end
		resp = ext_rsp.bresp;
		next_cycle(); // Response held back for a cycle
		ext_req.bready = 1'b1;
		next_cycle();
		ext_req.bready = 1'b0;
	endtask

	// granted is cleared when arready never comes
	task automatic bus_read(bus_pkg::addr_t addr, output bit granted, output bus_pkg::data_t data,
			output bus_pkg::resp_e resp);
		int n;
		ext_req.arvalid = 1'b1;
		ext_req.araddr = addr;
		ext_req.rready = 1'b0;
		granted = 1'b1;
		data = '0;
		resp = bus_pkg::OKAY;
		n = 0;
		@(negedge clk);
		while (!ext_rsp.arready) begin
			n++;
			if (n > BUS_TIMEOUT) begin
				granted = 1'b0;
				break;
			end
			@(negedge clk);
		end
		next_cycle();
		ext_req.arvalid = 1'b0;
		if (granted) begin
			n = 0;
			@(negedge clk);
			while (!ext_rsp.rvalid) begin
				n++;
				if (n > BUS_TIMEOUT) begin
					$display("No read data returned for address %h", addr);
					abort_run();
				end
				@(negedge clk);
			end
			data = ext_rsp.rdata;
			resp = ext_rsp.rresp;
			next_cycle(); // Response held back for a cycle
			ext_req.rready = 1'b1;
			next_cycle();
		end
		ext_req.rready = 1'b0;
	endtask

	function automatic bus_pkg::data_t merge_bytes(bus_pkg::data_t old, bus_pkg::data_t data,
			bus_pkg::strb_t strb);
		bus_pkg::data_t res;
		res = old;
		for (int i = 0; i < 4; i++) begin
			if (strb[i])
				res[8*i +: 8] = data[8*i +: 8];
		end
		return res;
	endfunction

	task automatic add_entry(bit is_write, bus_pkg::addr_t addr, bus_pkg::data_t data,
			bus_pkg::strb_t strb, bus_pkg::data_t exp_data, bus_pkg::resp_e exp_resp);
		entry_t e;
		e.is_write = is_write;
		e.addr = addr;
		e.data = data;
		e.strb = strb;
		e.exp_data = exp_data;
		e.exp_resp = exp_resp;
		stim_q.push_back(e);
	endtask

	// Partial write to a loaded word, then read it back
	task automatic add_write_read(int idx, bus_pkg::data_t data, bus_pkg::strb_t strb);
		model[idx] = merge_bytes(model[idx], data, strb);
		add_entry(1'b1, 4 * idx, data, strb, '0, bus_pkg::OKAY);
		add_entry(1'b0, 4 * idx, '0, '0, model[idx], bus_pkg::OKAY);
	endtask

	task automatic build_stimulus();
		for (int i = 0; i < IMG_WORDS; i++)
			add_entry(1'b0, 4 * i, '0, '0, model[i], bus_pkg::OKAY);
		add_write_read(1, 32'hDEAD_BEEF, 4'b0001);
		add_write_read(2, 32'h1234_5678, 4'b0110);
		add_write_read(7, 32'hCAFE_F00D, 4'b1000);
		add_write_read(2, 32'h9ABC_DEF0, 4'b1001);
		add_entry(1'b1, `SOC_MEM_END - 3, 32'h0BAD_F00D, 4'hF, '0, bus_pkg::OKAY);
		add_entry(1'b0, `SOC_MEM_END - 3, '0, '0, 32'h0BAD_F00D, bus_pkg::OKAY);
		// GPIO
		add_entry(1'b1, `SOC_GPIO_START + `SOC_GPIO_LED_OFS, 32'h1234_56A5, 4'hF, '0,
			bus_pkg::OKAY);
		add_entry(1'b0, `SOC_GPIO_START + `SOC_GPIO_LED_OFS, '0, '0, 32'h0000_00A5,
			bus_pkg::OKAY);
		add_entry(1'b0, `SOC_GPIO_START + `SOC_GPIO_SW_OFS, '0, '0, {28'd0, SW_PATTERN},
			bus_pkg::OKAY);
		add_entry(1'b0, `SOC_GPIO_START + 8, '0, '0, '0, bus_pkg::OKAY);
		// Unmapped
		add_entry(1'b0, 32'h0000_2000, '0, '0, '0, bus_pkg::DECERR);
		add_entry(1'b1, 32'h0000_2000, 32'hFFFF_FFFF, 4'hF, '0, bus_pkg::DECERR);
		add_entry(1'b0, 32'hFFFF_FFFC, '0, '0, '0, bus_pkg::DECERR);
	endtask

	initial begin
		bus_pkg::data_t rdata;
		bus_pkg::resp_e resp;
		bit granted;
		entry_t e;

		void'($urandom(32'haf8c));
		reset = 1'b1;
		sw = '0;
		uart_rx = 1'b1; // Idle line
		ext_req = '0;
		for (int i = 0; i < IMG_WORDS; i++)
			model[i] = $urandom();
		repeat (5) @(posedge clk);
		#DRIVE_DLY;
		reset = 1'b0;
		next_cycle();

		check_value("led_o", '0, led);
		check_value("loader_busy_o", '0, loader_busy);
		check_value("ext_rsp_o.bvalid", '0, ext_rsp.bvalid);
		check_value("ext_rsp_o.rvalid", '0, ext_rsp.rvalid);

		// Image: count then words, little-endian
		send_byte(8'(IMG_WORDS));
		assert (loader_busy === 1'b1)
		else begin
			$display("loader_busy_o did not rise after the first byte");
			abort_run();
		end
		repeat (3) send_byte(8'h00);
		for (int i = 0; i < IMG_WORDS; i++)
			send_word(model[i]);
		wait_load_done();

		build_stimulus();
		sw = SW_PATTERN;
		repeat (3) next_cycle(); // Switch synchronizer

		foreach (stim_q[i]) begin
			e = stim_q[i];
			if (e.is_write) begin
				bus_write(e.addr, e.data, e.strb, resp);
				check_value($sformatf("bresp @%h", e.addr), e.exp_resp, resp);
			end else begin
				bus_read(e.addr, granted, rdata, resp);
				assert (granted)
				else begin
					$display("No arready for the read at address %h", e.addr);
					abort_run();
				end
				check_value($sformatf("rdata @%h", e.addr), e.exp_data, rdata);
				check_value($sformatf("rresp @%h", e.addr), e.exp_resp, resp);
			end
		end
		check_value("led_o", 32'h0000_00A5, led);

		// Reprogram switch locks out the bus
		sw = SW_PATTERN | 4'b0010;
		repeat (2) next_cycle();
		check_value("led_o", '0, led);
		bus_read(`SOC_MEM_START, granted, rdata, resp);
		assert (!granted)
		else begin
			$display("External read was accepted while reprogramming");
			abort_run();
		end
		sw = SW_PATTERN;
		repeat (2) next_cycle();
		for (int i = 0; i < IMG_WORDS; i++) begin
			bus_read(4 * i, granted, rdata, resp);
			assert (granted)
			else begin
				$display("No arready after reprogramming ended, word %0d", i);
				abort_run();
			end
			check_value($sformatf("rdata word %0d", i), model[i], rdata);
			check_value($sformatf("rresp word %0d", i), bus_pkg::OKAY, resp);
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* files.f */
+incdir+rtl
rtl/bus_pkg.sv
rtl/serial_pkg.sv
rtl/uart_rx.sv
rtl/prog_loader.sv
rtl/axi_crossbar.sv
rtl/bram_axi.sv
rtl/gpio_axi.sv
rtl/soc_top.sv
bench/tb_clock.sv
bench/soc_props.sv
bench/soc_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP := soc_tb
FILELIST := files.f
OBJ_DIR := obj_dir
SIM := $(OBJ_DIR)/V$(TOP)
LOG := sim.log
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) rtl/soc_cfg.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "Simulation ended early"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
